/* Makefile */
# Verilator build and run of the keyword detector testbench

VERILATOR ?= verilator
TOP       ?= tb_ids
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard test/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A missing pass line also counts as failure, e.g. after an assertion stop
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+test
verilog/stream_pkg.sv
verilog/dfa_pkg.sv
verilog/packet_ingest.sv
verilog/keyword_dfa.sv
verilog/stream_matcher.sv
verilog/match_report.sv
verilog/ids_top.sv
test/tb_ids.sv

/* test/tb_ids_tasks.svh */
`ifndef TB_IDS_TASKS_SVH
`define TB_IDS_TASKS_SVH

// Reference model state
bit                       m_seen   [64];
bit                       m_enable [64];
int                       m_state  [64];
stream_pkg::match_count_t m_count = '0;
// Characters of the next packet
dfa_pkg::dfa_char_t       payload  [$];

task automatic drive_beat(input stream_pkg::beat_kind_t kind,
                          input stream_pkg::stream_id_t id,
                          input dfa_pkg::dfa_char_t     ch);
   @(negedge clk);
   beat.kind   = kind;
   beat.stream = id;
   beat.data   = ch;
endtask

// One-cycle config write mirrored in the model
task automatic set_enable(input stream_pkg::stream_id_t id, input bit en);
   @(negedge clk);
   cfg_we     = 1'b1;
   cfg_stream = id;
   cfg_enable = en;
   @(negedge clk);
   cfg_we       = 1'b0;
   m_enable[id] = en;
endtask

task automatic send_packet(input stream_pkg::stream_id_t id);
   drive_beat(stream_pkg::BEAT_HEADER, id, 8'h00);
   foreach (payload[i])
      drive_beat(stream_pkg::BEAT_DATA, id, payload[i]);
   drive_beat(stream_pkg::BEAT_TRAILER, id, 8'h00);
   // Mandatory idle gap
   drive_beat(stream_pkg::BEAT_IDLE, '0, 8'h00);
endtask

task automatic set_payload(input string s);
   payload.delete();
   for (int i = 0; i < s.len(); i++)
      payload.push_back(dfa_pkg::dfa_char_t'(s[i]));
endtask

// Keyword scan with the restart rule, then the end-of-packet rules
task automatic model_packet(input stream_pkg::stream_id_t id,
                            output stream_pkg::match_report_t exp);
   int s;
   bit flag;
   s    = m_seen[id] ? m_state[id] : 0;
   flag = 1'b0;
   foreach (payload[i])
   begin
      if (payload[i] == dfa_pkg::dfa_char_t'(KEY_TEXT[s]))
         s++;
      else if (payload[i] == dfa_pkg::dfa_char_t'(KEY_TEXT[0]))
         s = 1;
      else
         s = 0;
      // Scan restarts once the whole keyword is seen
      if (s == KEY_LEN)
      begin
         flag = 1'b1;
         s    = 0;
      end
   end
   m_seen[id] = 1'b1;
   if (m_enable[id])
   begin
      m_count     = m_count + stream_pkg::match_count_t'(flag);
      m_state[id] = s;
   end
   else
      flag = 1'b0;
   exp.stream = id;
   exp.fired  = flag;
   exp.count  = m_count;
endtask

task automatic run_payload(input string name, input stream_pkg::stream_id_t id);
   stream_pkg::match_report_t exp;
   send_packet(id);
   model_packet(id, exp);
   check_report(name, exp);
endtask

// Directed packet whose fired value is known up front
task automatic run_text(input string name, input stream_pkg::stream_id_t id,
                        input string s, input bit want_fired);
   stream_pkg::match_report_t exp;
   set_payload(s);
   send_packet(id);
   model_packet(id, exp);
   if (exp.fired != want_fired)
      abort_run($sformatf("%s: reference model disagrees with the directed case", name));
   check_report(name, exp);
endtask

task automatic test_reset_quiet();
   repeat (20)
   begin
      @(negedge clk);
      if (report_valid)
         abort_run("report_valid pulsed after reset with no packet sent");
   end
   set_enable(6'd1, 1'b1);
   run_text("first_match", 6'd1, "nntp", 1'b1);
endtask

task automatic test_disabled();
   stream_pkg::match_report_t exp;
   run_text("disabled_stream", 6'd2, "abnntpc", 1'b0);
   // Count still holds the single earlier hit
   set_enable(6'd3, 1'b1);
   set_payload("xyz");
   send_packet(6'd3);
   model_packet(6'd3, exp);
   check_count("count_unchanged", 16'd1);
endtask

task automatic test_saved_state();
   set_enable(6'd5, 1'b1);
   run_text("split_head", 6'd5, "xxnn", 1'b0);
   run_text("split_tail", 6'd5, "tpzz", 1'b1);
endtask

task automatic test_disabled_split();
   set_enable(6'd6, 1'b1);
   run_text("held_head", 6'd6, "nn", 1'b0);
   set_enable(6'd6, 1'b0);
   run_text("held_off", 6'd6, "tp", 1'b0);
   // Disabled packet left the saved prefix alone
   set_enable(6'd6, 1'b1);
   run_text("held_tail", 6'd6, "tp", 1'b1);
   // New stream ignores the prefix left by another one
   set_enable(6'd7, 1'b1);
   run_text("other_head", 6'd7, "qnn", 1'b0);
   set_enable(6'd8, 1'b1);
   run_text("fresh_stream", 6'd8, "tp", 1'b0);
endtask

task automatic test_interleave();
   set_enable(6'd10, 1'b1);
   set_enable(6'd11, 1'b1);
   set_enable(6'd12, 1'b1);
   run_text("mix_a1", 6'd10, "nn", 1'b0);
   run_text("mix_b1", 6'd11, "n", 1'b0);
   run_text("mix_c1", 6'd12, "nnt", 1'b0);
   run_text("mix_a2", 6'd10, "tp", 1'b1);
   run_text("mix_b2", 6'd11, "ntp", 1'b1);
   run_text("mix_c2", 6'd12, "p", 1'b1);
   run_text("mix_b3", 6'd11, "tpx", 1'b0);
endtask

`endif

/* test/tb_ids.sv */
`timescale 1ns/1ps

module tb_ids;

   // Keyword as sent on the wire with the first character first
   localparam string KEY_TEXT = "nntp";
   localparam int    KEY_LEN  = 4;
   // Random run size
   localparam int RAND_PKTS = 200;
   localparam int MAX_DATA  = 40;
   // Each packet takes its data beats plus header, trailer, gap, report latency and a config write
   // Directed tests add a few hundred cycles, then double for margin
   localparam int TIMEOUT_CYCLES = 2 * (RAND_PKTS * (MAX_DATA + 8) + 500);
   // Cycles from the idle gap until report_valid must show
   localparam int REPORT_WAIT = 8;

   logic                      clk;
   logic                      rst_n;
   stream_pkg::packet_beat_t  beat;
   logic                      cfg_we;
   stream_pkg::stream_id_t    cfg_stream;
   logic                      cfg_enable;
   stream_pkg::match_report_t report;
   logic                      report_valid;

   int          cycles = 0;
   logic [31:0] lcg_state;

   ids_top #(
      .KEY_LEN (KEY_LEN),
      // "nntp" with the first character in the low byte
      .KEYWORD (128'h70746e6e)
   ) dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat         (beat),
      .cfg_we       (cfg_we),
      .cfg_stream   (cfg_stream),
      .cfg_enable   (cfg_enable),
      .report       (report),
      .report_valid (report_valid)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Hard limit on the run length
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         abort_run("Timeout: the run did not finish within the cycle limit");
   end

   // Stops the run at the first error
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // Linear congruential generator
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Mostly keyword letters so matches happen often
   function automatic dfa_pkg::dfa_char_t random_char();
      logic [31:0] r;
      r = lcg_next();
      if (r[31:30] != 2'b00)
         return dfa_pkg::dfa_char_t'(KEY_TEXT[int'(r[29:22]) % KEY_LEN]);
      return r[21:14];
   endfunction

   // Waits on falling edges, where outputs are stable
   task automatic wait_report(input string name);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!report_valid)
      begin
         waited++;
         if (waited > REPORT_WAIT)
            abort_run($sformatf("%s: no report_valid after the packet", name));
         else
            @(negedge clk);
      end
   endtask

   task automatic check_report(input string name, input stream_pkg::match_report_t exp);
      wait_report(name);
      if (report !== exp)
         abort_run($sformatf(
            "Mismatch %s: expected stream %0d fired %0d count %0d, actual %0d %0d %0d",
            name, exp.stream, exp.fired, exp.count,
            report.stream, report.fired, report.count));
   endtask

   task automatic check_count(input string name, input stream_pkg::match_count_t exp);
      wait_report(name);
      if (report.count !== exp)
         abort_run($sformatf("Mismatch %s: expected count %0d, actual %0d",
                             name, exp, report.count));
   endtask

   `include "tb_ids_tasks.svh"

   // Random enables and characters over eight reused streams
   task automatic test_random();
      logic [31:0]            r;
      stream_pkg::stream_id_t id;
      int                     len;
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         r  = lcg_next();
         id = stream_pkg::stream_id_t'(32 + int'(r[31:29]));
         // A stream may open disabled and only later save a state
         if (!m_seen[id] || r[28:27] == 2'b00)
            set_enable(id, r[26]);
         len = int'(r[23:16]) % (MAX_DATA + 1);
         payload.delete();
         repeat (len)
            payload.push_back(random_char());
         run_payload($sformatf("random_%0d", p), id);
      end
   endtask

   initial
   begin
      lcg_state  = 32'h81329584;
      rst_n      = 1'b0;
      beat       = '0;
      cfg_we     = 1'b0;
      cfg_stream = '0;
      cfg_enable = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      test_reset_quiet();
      test_disabled();
      test_saved_state();
      test_disabled_split();
      test_interleave();
      test_random();
      $display("Test OK");
      $finish;
   end

endmodule

/* verilog/dfa_pkg.sv */
package dfa_pkg;

   // Width of the automaton state
   localparam int STATE_W = 11;

   // Input character
   typedef logic [7:0] dfa_char_t;

   // Number of keyword characters matched so far
   typedef logic [STATE_W-1:0] dfa_state_t;

endpackage

/* verilog/ids_top.sv */
`timescale 1ns/1ps

module ids_top #(
   parameter int unsigned  KEY_LEN = 4,
   // "nntp", first character in the low byte
   parameter logic [127:0] KEYWORD = 128'h70746e6e
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  stream_pkg::packet_beat_t  beat,
   input  logic                      cfg_we,
   input  stream_pkg::stream_id_t    cfg_stream,
   input  logic                      cfg_enable,
   output stream_pkg::match_report_t report,
   output logic                      report_valid
);

   // Ingest to automaton
   logic                     char_valid;
   dfa_pkg::dfa_char_t       char_in;
   // Ingest to matcher
   logic                     load_state;
   logic                     new_stream;
   stream_pkg::stream_id_t   stream_id;
   logic                     eop;
   logic                     enable;
   // Matcher and automaton
   logic                     state_valid;
   dfa_pkg::dfa_state_t      state_in;
   dfa_pkg::dfa_state_t      state_out;
   logic                     accept;
   // Matcher to report
   logic                     fired;
   stream_pkg::match_count_t count;
   logic                     eop_done;

   packet_ingest u_ingest (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat       (beat),
      .cfg_we     (cfg_we),
      .cfg_stream (cfg_stream),
      .cfg_enable (cfg_enable),
      .char_valid (char_valid),
      .char_in    (char_in),
      .load_state (load_state),
      .new_stream (new_stream),
      .stream_id  (stream_id),
      .eop        (eop),
      .enable     (enable)
   );

   keyword_dfa #(
      .KEY_LEN (KEY_LEN),
      .KEYWORD (KEYWORD)
   ) u_dfa (
      .clk         (clk),
      .rst_n       (rst_n),
      .char_valid  (char_valid),
      .char_in     (char_in),
      .state_valid (state_valid),
      .state_in    (state_in),
      .state_out   (state_out),
      .accept      (accept)
   );

   stream_matcher u_matcher (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_state  (load_state),
      .new_stream  (new_stream),
      .stream_id   (stream_id),
      .eop         (eop),
      .enable      (enable),
      .accept      (accept),
      .state_out   (state_out),
      .state_valid (state_valid),
      .state_in    (state_in),
      .fired       (fired),
      .count       (count),
      .eop_done    (eop_done)
   );

   match_report u_report (
      .clk          (clk),
      .rst_n        (rst_n),
      .eop_done     (eop_done),
      .fired        (fired),
      .count        (count),
      .stream_id    (stream_id),
      .report       (report),
      .report_valid (report_valid)
   );

endmodule

/* verilog/keyword_dfa.sv */
`timescale 1ns/1ps

module keyword_dfa #(
   parameter int unsigned  KEY_LEN = 4,
   parameter logic [127:0] KEYWORD = 128'h70746e6e
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                char_valid,
   input  dfa_pkg::dfa_char_t  char_in,
   input  logic                state_valid,
   input  dfa_pkg::dfa_state_t state_in,
   output dfa_pkg::dfa_state_t state_out,
   output logic                accept
);

   // Full keyword length as a state value
   localparam dfa_pkg::dfa_state_t LAST = dfa_pkg::dfa_state_t'(KEY_LEN);
   localparam dfa_pkg::dfa_state_t ONE  = dfa_pkg::dfa_state_t'(1);

   // Keyword must fit in 16 bytes
   if (KEY_LEN < 1 || KEY_LEN > 16)
   begin : g_bad_len
      $error("keyword_dfa: KEY_LEN out of range");
   end

   dfa_pkg::dfa_state_t state_q;
   dfa_pkg::dfa_state_t base;
   dfa_pkg::dfa_state_t next_state;
   dfa_pkg::dfa_char_t  expect_char;
   dfa_pkg::dfa_char_t  first_char;
   logic                hit;
   logic                done;

   // Restored state overrides the running one
   assign base = state_valid ? state_in : state_q;

   // Next keyword character after the matched prefix
   // base stays below KEY_LEN so four bits index it
   assign expect_char = KEYWORD[{base[3:0], 3'b000} +: 8];
   assign first_char  = KEYWORD[7:0];

   assign hit  = (char_in == expect_char);
   assign done = hit && ((base + ONE) == LAST);

   always_comb
   begin
      next_state = base;
      if (char_valid)
      begin
         if (done)
            next_state = '0;
         else if (hit)
            next_state = base + ONE;
         // Restart rule on a mismatch
         else if (char_in == first_char)
            next_state = ONE;
         else
            next_state = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
         accept  <= 1'b0;
      end
      else
      begin
         state_q <= next_state;
         // One-cycle pulse after the completing character
         accept  <= char_valid && done;
      end
   end

   assign state_out = state_q;

   // Full length always wraps to 0, restored states included
   a_state_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      state_q < LAST);

endmodule

/* verilog/match_report.sv */
`timescale 1ns/1ps

module match_report (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      eop_done,
   input  logic                      fired,
   input  stream_pkg::match_count_t  count,
   input  stream_pkg::stream_id_t    stream_id,
   output stream_pkg::match_report_t report,
   output logic                      report_valid
);

   // Stream id as it stood in the eop cycle
   stream_pkg::stream_id_t   stream_q;
   // Count of the previous report
   stream_pkg::match_count_t last_count;

   // One stage behind lines up with eop_done
   // A header right after the idle gap has already moved stream_id
   always_ff @(posedge clk)
   begin
      stream_q <= stream_id;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         last_count <= '0;
      else if (eop_done)
         last_count <= count;
   end

   always_comb
   begin
      report.stream = stream_q;
      report.fired  = fired;
      report.count  = count;
   end

   assign report_valid = eop_done;

   // Count moves only by the reported flag
   a_count_step: assert property (
      @(posedge clk) disable iff (!rst_n)
      eop_done |-> (count == last_count + stream_pkg::match_count_t'(fired)));

endmodule

/* verilog/packet_ingest.sv */
`timescale 1ns/1ps

module packet_ingest (
   input  logic                     clk,
   input  logic                     rst_n,
   input  stream_pkg::packet_beat_t beat,
   input  logic                     cfg_we,
   input  stream_pkg::stream_id_t   cfg_stream,
   input  logic                     cfg_enable,
   output logic                     char_valid,
   output dfa_pkg::dfa_char_t       char_in,
   output logic                     load_state,
   output logic                     new_stream,
   output stream_pkg::stream_id_t   stream_id,
   output logic                     eop,
   output logic                     enable
);

   localparam int NUM_STREAMS = 2 ** $bits(stream_pkg::stream_id_t);

   // Streams seen since reset
   logic [NUM_STREAMS-1:0] seen;
   // Per-stream enable bits from the config port
   logic [NUM_STREAMS-1:0] enable_map;
   // First trailer stage, and the enable bit sampled alongside it
   logic                   eop_d1;
   logic                   enable_d1;
   // Decoded beat kind
   logic                   is_header;
   logic                   is_data;
   logic                   is_trailer;

   assign is_header  = (beat.kind == stream_pkg::BEAT_HEADER);
   assign is_data    = (beat.kind == stream_pkg::BEAT_DATA);
   assign is_trailer = (beat.kind == stream_pkg::BEAT_TRAILER);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         char_valid <= 1'b0;
         load_state <= 1'b0;
         new_stream <= 1'b0;
         eop_d1     <= 1'b0;
         eop        <= 1'b0;
         seen       <= '0;
         enable_map <= '0;
      end
      else
      begin
         char_valid <= is_data;
         load_state <= is_header;
         // Trailer goes through two stages
         // so the accept of the last character lands first
         eop_d1     <= is_trailer;
         eop        <= eop_d1;
         if (is_header)
         begin
            // Unseen stream restarts from state 0 in the matcher
            new_stream        <= !seen[beat.stream];
            seen[beat.stream] <= 1'b1;
         end
         if (cfg_we)
            enable_map[cfg_stream] <= cfg_enable;
      end
   end

   // Payload path
   always_ff @(posedge clk)
   begin
      char_in <= beat.data;
      // Stream id holds until the next header
      if (is_header)
         stream_id <= beat.stream;
      // Enable bit follows the trailer down the pipe
      enable_d1 <= enable_map[stream_id];
      enable    <= enable_d1;
   end

   // Every packet closes with a trailer before the next header
   a_no_header_after_data: assert property (
      @(posedge clk) disable iff (!rst_n)
      is_data |=> (beat.kind != stream_pkg::BEAT_HEADER));

   // Idle gap after each trailer keeps eop apart from the next load
   a_idle_after_trailer: assert property (
      @(posedge clk) disable iff (!rst_n)
      is_trailer |=> (beat.kind == stream_pkg::BEAT_IDLE));

endmodule

/* verilog/stream_matcher.sv */
`timescale 1ns/1ps

module stream_matcher (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     load_state,
   input  logic                     new_stream,
   input  stream_pkg::stream_id_t   stream_id,
   input  logic                     eop,
   input  logic                     enable,
   input  logic                     accept,
   input  dfa_pkg::dfa_state_t      state_out,
   output logic                     state_valid,
   output dfa_pkg::dfa_state_t      state_in,
   output logic                     fired,
   output stream_pkg::match_count_t count,
   output logic                     eop_done
);

   localparam int NUM_STREAMS = 2 ** $bits(stream_pkg::stream_id_t);

   // Saved automaton state per stream
   dfa_pkg::dfa_state_t state_mem [NUM_STREAMS];

   // Set by any accept in the current packet
   logic match_flag;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_valid <= 1'b0;
         match_flag  <= 1'b0;
         count       <= '0;
         eop_done    <= 1'b0;
      end
      else
      begin
         // Restored state reaches the automaton next cycle
         state_valid <= load_state;
         eop_done    <= eop;

         // New packet starts with no match
         if (load_state)
            match_flag <= 1'b0;

         if (accept)
            match_flag <= 1'b1;

         // Finalize at end of packet
         if (eop)
         begin
            if (enable)
               count <= count + stream_pkg::match_count_t'(match_flag);
            else
               // Disabled stream reports no hit
               match_flag <= 1'b0;
         end
      end
   end

   // State save and restore
   always_ff @(posedge clk)
   begin
      // Only an enabled packet saves the state it ended in
      if (eop && enable)
         state_mem[stream_id] <= state_out;

      // Unseen stream starts clean and a known one picks up where it left off
      if (load_state)
      begin
         if (new_stream)
         begin
            state_in             <= '0;
            // Entry holds 0 until an enabled packet saves a state
            state_mem[stream_id] <= '0;
         end
         else
            state_in <= state_mem[stream_id];
      end
   end

   // Flag holds its final value while eop_done is high
   assign fired = match_flag;

   // Restore and save of the same packet never overlap
   a_load_eop_apart: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(load_state && eop));

endmodule

/* verilog/stream_pkg.sv */
package stream_pkg;

   // Stream number, 64 streams
   typedef logic [5:0] stream_id_t;

   // Global count of packets that hit the keyword
   typedef logic [15:0] match_count_t;

   // Beat kinds on the packet input
   typedef enum logic [1:0] {
      BEAT_IDLE    = 2'd0,
      BEAT_HEADER  = 2'd1,
      BEAT_DATA    = 2'd2,
      BEAT_TRAILER = 2'd3
   } beat_kind_t;

   // One input beat, 16 bits
   // The stream field is only meaningful on a header
   typedef struct packed {
      beat_kind_t kind;
      stream_id_t stream;
      logic [7:0] data;
   } packet_beat_t;

   // Per-packet result, 23 bits
   typedef struct packed {
      stream_id_t   stream;
      logic         fired;
      match_count_t count;
   } match_report_t;

endpackage
